// ==== dma_noc_req.f ====
+incdir+src
src/dma_req_pkg.sv
src/dma_req_arbiter.sv
src/dma_req_fsm.sv
src/dma_req_burst_counter.sv
src/dma_req_flit_builder.sv
src/dma_noc_req.sv
sim/dma_noc_req_chk.sv
sim/dma_noc_req_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the DMA request path testbench with Verilator and run it.
# The exit status of the simulation is the result of the run.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  --top-module dma_noc_req_tb \
  -f dma_noc_req.f \
  -o dma_noc_req_sim

./obj_dir/dma_noc_req_sim

// ==== sim/dma_noc_req_chk.sv ====
/*
 * Protocol checker for the DMA request path, bound to the top level
 *   NoC flit held under back-pressure
 *   Data words taken only with an accepted data flit
 *   Quiet outputs after reset, one-cycle start pulse
 */

`timescale 1ns/1ps
`default_nettype none

module dma_noc_req_chk import dma_req_pkg::*; (
  input wire logic      clk,
  input wire logic      rst,
  input wire noc_flit_t flit,
  input wire logic      flit_valid,
  input wire logic      flit_ready,
  input wire logic      data_valid,
  input wire logic      data_ready,
  input wire logic      data_start
);

  //////////////////////////////////////////////////////////////////////
  // NoC side
  //////////////////////////////////////////////////////////////////////

  // Stalled flit neither drops nor changes
  a_flit_hold: assert property (@(posedge clk) disable iff (rst)
    flit_valid && !flit_ready |=> flit_valid && $stable(flit))
    else $error("flit dropped or changed while stalled");

  // Source word leaves only inside an accepted data flit
  a_data_ready: assert property (@(posedge clk) disable iff (rst)
    data_ready |-> flit_valid && flit_ready && data_valid && flit.ftype != flit_header)
    else $error("data_ready without an accepted data flit");

  //////////////////////////////////////////////////////////////////////
  // Control side
  //////////////////////////////////////////////////////////////////////

  a_reset_quiet: assert property (@(posedge clk)
    rst |=> !flit_valid && !data_ready && !data_start)
    else $error("outputs active right after reset");

  a_start_pulse: assert property (@(posedge clk) disable iff (rst)
    data_start |=> !data_start)
    else $error("data_start wider than one cycle");

  // FSM is still idle during the start cycle
  a_start_idle: assert property (@(posedge clk) disable iff (rst)
    data_start |-> !flit_valid)
    else $error("data_start while a flit is offered");

endmodule

`default_nettype wire

// ==== sim/dma_noc_req_tb.sv ====
/*
 * Testbench of the DMA request path
 *   Clock, reset, request table, data source and response models
 *   Arbitration and expected-flit model with immediate checks
 *   LFSR back-pressure, watchdog and scripted request list
 */

`timescale 1ns/1ps
`default_nettype none

`include "dma_req_config.svh"

module dma_noc_req_tb import dma_req_pkg::*; ();

  localparam int MAX_WORDS     = `DMA_PACKET_FLITS - 2;
  localparam int REQS_PER_LIST = 12;
  // List runs once steady and once under random back-pressure
  localparam int WATCHDOG_CYC  = 2 * REQS_PER_LIST * 200;

  logic        clk = 1'b0;
  logic        rst = 1'b1;
  entry_mask_t table_valid = '0;
  entry_idx_t  read_idx;
  dma_desc_t   desc;
  logic        done_en = 1'b0;
  entry_idx_t  done_idx = '0;
  logic        data_start;
  logic        data_valid = 1'b0;
  word_t       data_word = '0;
  logic        data_ready;
  noc_flit_t   flit;
  logic        flit_valid;
  logic        flit_ready = 1'b0;

  // Table, stimulus and model state
  dma_desc_t   table_m [`DMA_TABLE_ENTRIES] = '{default: '0};
  logic [31:0] lfsr = 32'h1dbfbc85;
  logic        rnd_mode = 1'b0;
  int          resp_delay = 2;
  noc_flit_t   exp_q [$];
  entry_mask_t open_m = '0;
  int          resp_cnt [`DMA_TABLE_ENTRIES] = '{default: 0};
  logic        busy = 1'b0;
  entry_idx_t  cur_idx = '0;
  entry_idx_t  last_idx = entry_idx_t'(`DMA_TABLE_ENTRIES - 1);
  entry_idx_t  due_idx = '0;
  logic        start_due = 1'b0;
  int          reqs_done = 0;
  logic        quiet = 1'b0;
  addr_t       src_raddr = '0;
  int          src_n = 0;
  int          src_left = 0;

  //////////////////////////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////////////////////////

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Regression failed");
    $fatal(1);
  endtask

  // Fibonacci LFSR, taps 32 22 2 1, one step per bit
  function automatic logic rand_bit();
    logic fb;
    fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
    lfsr = {lfsr[30:0], fb};
    return fb;
  endfunction

  // Source word n of a request
  function automatic word_t src_word(input addr_t raddr, input int n);
    return (raddr ^ 32'h5a5a_0000) + word_t'(n);
  endfunction

  function automatic word_t hdr_word(input entry_idx_t idx, input tile_t dest,
                                     input logic [1:0] kind, input logic last,
                                     input size_t size);
    header_t h;
    h        = '0;
    h.dest   = dest;
    h.pclass = 3'd2;
    h.pkt_id = idx;
    h.src    = tile_t'(`DMA_TILE_ID);
    h.kind   = kind;
    h.last   = last;
    h.size   = size;
    return h;
  endfunction

  // Round-robin pick, search starts above the last grant
  function automatic entry_idx_t next_grant(input entry_idx_t last, input entry_mask_t elig);
    entry_idx_t c;
    entry_idx_t pick;
    pick = last;
    for (int i = `DMA_TABLE_ENTRIES; i >= 1; i--) begin
      c = entry_idx_t'((int'(last) + i) % `DMA_TABLE_ENTRIES);
      if (elig[c]) begin
        pick = c;
      end
    end
    return pick;
  endfunction

  // Whole flit sequence of one request
  task automatic push_expected(input entry_idx_t idx);
    dma_desc_t d;
    int        left;
    int        done;
    int        n;
    d = table_m[idx];
    if (d.dir) begin
      done = 0;
      left = int'(d.size);
      while (left > 0) begin
        n = (left > MAX_WORDS) ? MAX_WORDS : left;
        exp_q.push_back('{flit_header, hdr_word(idx, d.rtile, 2'd0, left == n, size_t'(n))});
        exp_q.push_back('{flit_payload, d.raddr + addr_t'(4 * done)});
        for (int k = 0; k < n; k++) begin
          exp_q.push_back('{(k == n - 1) ? flit_last : flit_payload,
                            src_word(d.raddr, done + k)});
        end
        done = done + n;
        left = left - n;
      end
    end else begin
      exp_q.push_back('{flit_header, hdr_word(idx, d.rtile, 2'd1, 1'b1, '0)});
      exp_q.push_back('{flit_payload, word_t'(d.size)});
      exp_q.push_back('{flit_payload, d.raddr});
      exp_q.push_back('{flit_last, d.laddr});
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // DUT, clock and models
  //////////////////////////////////////////////////////////////////////

  dma_noc_req dut_i (
    .clk        (clk),
    .rst        (rst),
    .table_valid(table_valid),
    .read_idx   (read_idx),
    .desc       (desc),
    .done_en    (done_en),
    .done_idx   (done_idx),
    .data_start (data_start),
    .data_valid (data_valid),
    .data_word  (data_word),
    .data_ready (data_ready),
    .flit       (flit),
    .flit_valid (flit_valid),
    .flit_ready (flit_ready)
  );

  bind dma_noc_req dma_noc_req_chk chk_i (
    .clk       (clk),
    .rst       (rst),
    .flit      (flit),
    .flit_valid(flit_valid),
    .flit_ready(flit_ready),
    .data_valid(data_valid),
    .data_ready(data_ready),
    .data_start(data_start)
  );

  always #5 clk = ~clk;

  // Table read port answers in the same cycle
  assign desc = table_m[read_idx];

  // NoC ready and local data source, one LFSR user for a fixed sequence
  always @(posedge clk) begin : drive
    logic hold;
    if (rst) begin
      flit_ready <= 1'b0;
      data_valid <= 1'b0;
    end else begin
      flit_ready <= rnd_mode ? (rand_bit() | rand_bit()) : 1'b1;
      if (data_valid && data_ready) begin
        src_n    = src_n + 1;
        src_left = src_left - 1;
      end
      if (data_start && desc.dir) begin
        src_raddr = desc.raddr;
        src_n     = 0;
        src_left  = int'(desc.size);
      end
      // Offered word stays until taken
      hold = data_valid && !data_ready;
      if (!hold) begin
        if (src_left > 0) begin
          data_valid <= rnd_mode ? rand_bit() : 1'b1;
          data_word  <= src_word(src_raddr, src_n);
        end else begin
          data_valid <= 1'b0;
        end
      end
    end
  end

  // Arbitration, expected flits, open responses and done pulses
  always @(posedge clk) begin : model
    noc_flit_t   want;
    entry_mask_t elig;
    logic        fired;
    if (rst) begin
      done_en <= 1'b0;
    end else begin
      elig = table_valid & ~open_m & {`DMA_TABLE_ENTRIES{!busy && !data_start}};

      // Response countdown, one done pulse per cycle
      fired = 1'b0;
      done_en <= 1'b0;
      for (int i = 0; i < `DMA_TABLE_ENTRIES; i++) begin
        if (resp_cnt[i] > 1) begin
          resp_cnt[i] = resp_cnt[i] - 1;
        end else if (resp_cnt[i] == 1 && !fired) begin
          done_en     <= 1'b1;
          done_idx    <= entry_idx_t'(i);
          resp_cnt[i] = 0;
          fired       = 1'b1;
        end
      end

      assert (data_start == start_due)
        else abort_run($sformatf("error: data_start 0x%h, expected 0x%h",
                                 data_start, start_due));
      if (data_start) begin
        assert (read_idx == due_idx)
          else abort_run($sformatf("error: read_idx 0x%h, expected 0x%h", read_idx, due_idx));
      end

      if (flit_valid && flit_ready) begin
        assert (exp_q.size() != 0)
          else abort_run("a flit was sent while no request was in progress");
        want = exp_q.pop_front();
        assert (flit == want)
          else abort_run($sformatf("error: flit 0x%h, expected 0x%h", flit, want));
        // Last flit of the request, response now open
        if (exp_q.size() == 0) begin
          busy              = 1'b0;
          open_m[cur_idx]   = 1'b1;
          resp_cnt[cur_idx] = resp_delay;
          reqs_done         <= reqs_done + 1;
        end
      end

      if (done_en) begin
        open_m[done_idx] = 1'b0;
      end

      if (data_start) begin
        push_expected(due_idx);
        busy    = 1'b1;
        cur_idx = due_idx;
      end

      // Grant taken now, start pulse due next cycle
      start_due = |elig;
      if (|elig) begin
        due_idx  = next_grant(last_idx, elig);
        last_idx = due_idx;
      end
      quiet <= !busy && (open_m == '0) && !start_due;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Scripted requests
  //////////////////////////////////////////////////////////////////////

  task automatic set_entry(input int idx, input logic dir, input tile_t rtile,
                           input addr_t laddr, input addr_t raddr, input size_t size);
    table_m[idx] <= '{dir: dir, rtile: rtile, laddr: laddr, raddr: raddr, size: size};
  endtask

  task automatic wait_reqs(input int n);
    int target;
    target = reqs_done + n;
    do @(posedge clk); while (reqs_done < target);
  endtask

  task automatic wait_quiet();
    do @(posedge clk); while (!quiet);
  endtask

  task automatic run_list();
    // Short L2R, held open, then issued again after its done
    set_entry(0, 1'b1, 5'd7, 32'h0000_0400, 32'h0001_0000, 12'd5);
    resp_delay  <= 40;
    table_valid <= 4'b0001;
    wait_reqs(2);
    table_valid <= '0;
    wait_quiet();
    // L2R split into 14, 14 and 2 words
    set_entry(1, 1'b1, 5'd12, 32'h0000_0800, 32'h0002_0000, 12'd30);
    resp_delay  <= 3;
    table_valid <= 4'b0010;
    wait_reqs(1);
    table_valid <= '0;
    wait_quiet();
    // R2L request
    set_entry(2, 1'b0, 5'd30, 32'h0000_8000, 32'h4000_0040, 12'd100);
    table_valid <= 4'b0100;
    wait_reqs(1);
    table_valid <= '0;
    wait_quiet();
    // All entries valid, round-robin order
    set_entry(1, 1'b1, 5'd1, 32'h0000_0c00, 32'h0003_0100, 12'd17);
    set_entry(3, 1'b1, 5'd31, 32'h0000_0010, 32'h0004_0ffc, 12'd1);
    resp_delay  <= 2;
    table_valid <= 4'b1111;
    wait_reqs(8);
    table_valid <= '0;
    wait_quiet();
  endtask

  initial begin : stimulus
    repeat (5) @(posedge clk);
    rst <= 1'b0;
    run_list();
    // Same list under random back-pressure
    rnd_mode <= 1'b1;
    run_list();
    repeat (10) @(posedge clk);
    $display("Regression passed");
    $finish;
  end

  initial begin : watchdog
    repeat (WATCHDOG_CYC) @(posedge clk);
    abort_run("timeout, the request list did not finish in time");
  end

endmodule

`default_nettype wire

// ==== src/dma_noc_req.sv ====
/*
 * Top of the DMA request path
 *   Arbiter, FSM, burst counter and flit builder
 *   Request table, data source and NoC output ports
 */

`timescale 1ns/1ps
`default_nettype none

module dma_noc_req import dma_req_pkg::*; (
  input  wire logic        clk,
  input  wire logic        rst,
  // Request table
  input  wire entry_mask_t table_valid,
  output entry_idx_t       read_idx,
  input  wire dma_desc_t   desc,
  // Response path feedback
  input  wire logic        done_en,
  input  wire entry_idx_t  done_idx,
  // Local data source
  output logic             data_start,
  input  wire logic        data_valid,
  input  wire word_t       data_word,
  output logic             data_ready,
  // NoC output
  output noc_flit_t        flit,
  output logic             flit_valid,
  input  wire logic        flit_ready
);

  req_state_t state;
  logic       idle;
  logic       issue_done;
  logic       load;
  logic       pkt_open;
  logic       step;
  logic       pkt_last;
  logic       req_last;
  size_t      done_words;
  pkt_len_t   pkt_len;

  ////////////////////////////////////////////////////////////////////
  // Entry selection, the grant addresses the table directly
  ////////////////////////////////////////////////////////////////////

  dma_req_arbiter arb_i (
    .clk        (clk),
    .rst        (rst),
    .table_valid(table_valid),
    .idle       (idle),
    .issue_done (issue_done),
    .done_en    (done_en),
    .done_idx   (done_idx),
    .grant_idx  (read_idx),
    .start      (data_start)
  );

  dma_req_burst_counter cnt_i (
    .clk       (clk),
    .rst       (rst),
    .load      (load),
    .pkt_open  (pkt_open),
    .step      (step),
    .req_size  (desc.size),
    .done_words(done_words),
    .pkt_len   (pkt_len),
    .pkt_last  (pkt_last),
    .req_last  (req_last)
  );

  ////////////////////////////////////////////////////////////////////
  // Sequencing and flit contents
  ////////////////////////////////////////////////////////////////////

  dma_req_fsm fsm_i (
    .clk       (clk),
    .rst       (rst),
    .start     (data_start),
    .is_l2r    (desc.dir),
    .flit_ready(flit_ready),
    .data_valid(data_valid),
    .pkt_last  (pkt_last),
    .req_last  (req_last),
    .state     (state),
    .idle      (idle),
    .flit_valid(flit_valid),
    .data_ready(data_ready),
    .load      (load),
    .pkt_open  (pkt_open),
    .step      (step),
    .issue_done(issue_done)
  );

  dma_req_flit_builder bld_i (
    .state     (state),
    .desc      (desc),
    .grant_idx (read_idx),
    .done_words(done_words),
    .pkt_len   (pkt_len),
    .pkt_last  (pkt_last),
    .data_word (data_word),
    .flit      (flit)
  );

endmodule

`default_nettype wire

// ==== src/dma_req_arbiter.sv ====
/*
 * Table entry arbiter of the DMA request path
 *   Round-robin one-hot grant over eligible entries
 *   Open-response mask, set on issue and cleared by the response path
 *   Start pulse for the FSM and the data source
 */

`timescale 1ns/1ps
`default_nettype none

`include "dma_req_config.svh"

module dma_req_arbiter import dma_req_pkg::*; (
  input  wire logic        clk,
  input  wire logic        rst,
  input  wire entry_mask_t table_valid,
  input  wire logic        idle,
  input  wire logic        issue_done,
  input  wire logic        done_en,
  input  wire entry_idx_t  done_idx,
  output entry_idx_t       grant_idx,
  output logic             start
);

  entry_mask_t grant;
  entry_mask_t nxt_grant;
  entry_mask_t open_mask;
  entry_mask_t nxt_open;
  entry_mask_t eligible;
  entry_idx_t  cand;

  ////////////////////////////////////////////////////////////////////
  // Arbitration
  ////////////////////////////////////////////////////////////////////

  // Only look while idle, and not during the start cycle itself
  assign eligible = table_valid & ~open_mask & {`DMA_TABLE_ENTRIES{idle & ~start}};

  // One-hot grant to index
  always_comb begin
    grant_idx = '0;
    for (int i = 0; i < `DMA_TABLE_ENTRIES; i++) begin
      if (grant[i]) begin
        grant_idx = entry_idx_t'(i);
      end
    end
  end

  // Search starts above the last grant, last grant has lowest priority
  always_comb begin
    nxt_grant = grant;
    cand      = grant_idx;
    for (int i = 1; i <= `DMA_TABLE_ENTRIES; i++) begin
      cand = grant_idx + entry_idx_t'(i);
      if (eligible[cand] && nxt_grant == grant) begin
        nxt_grant = entry_mask_t'(1) << cand;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////
  // Open responses
  ////////////////////////////////////////////////////////////////////

  always_comb begin
    nxt_open = open_mask;
    // Last flit of the granted request went out
    if (issue_done) begin
      nxt_open = nxt_open | grant;
    end
    if (done_en) begin
      nxt_open[done_idx] = 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      // Entry 0 wins first
      grant     <= entry_mask_t'(1) << (`DMA_TABLE_ENTRIES - 1);
      open_mask <= '0;
      start     <= 1'b0;
    end else begin
      grant     <= nxt_grant;
      open_mask <= nxt_open;
      // High for exactly one cycle, the grant is held meanwhile
      start     <= |eligible;
    end
  end

endmodule

`default_nettype wire

// ==== src/dma_req_burst_counter.sv ====
/*
 * Word counters of the DMA request path
 *   Words done in the request, advanced per packet
 *   Words done in the current packet
 *   Packet sizing and end-of-packet and end-of-request flags
 */

`timescale 1ns/1ps
`default_nettype none

`include "dma_req_config.svh"

module dma_req_burst_counter import dma_req_pkg::*; (
  input  wire logic  clk,
  input  wire logic  rst,
  input  wire logic  load,
  input  wire logic  pkt_open,
  input  wire logic  step,
  input  wire size_t req_size,
  output size_t      done_words,
  output pkt_len_t   pkt_len,
  output logic       pkt_last,
  output logic       req_last
);

  size_t    remaining;
  pkt_len_t pkt_cnt;

  ////////////////////////////////////////////////////////////////////
  // Packet sizing
  ////////////////////////////////////////////////////////////////////

  // Words still to send, done_words only moves at packet ends
  assign remaining = req_size - done_words;

  // Full packet, or the tail of the request
  assign pkt_len = (remaining > size_t'(`DMA_MAX_PAYLOAD)) ?
                   pkt_len_t'(`DMA_MAX_PAYLOAD) : pkt_len_t'(remaining);

  // Word now on the bus closes the packet
  assign pkt_last = ((pkt_cnt + pkt_len_t'(1)) == pkt_len);

  // ... and also the request
  assign req_last = pkt_last && ((done_words + size_t'(pkt_len)) == req_size);

  ////////////////////////////////////////////////////////////////////
  // Counters
  ////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      done_words <= '0;
      pkt_cnt    <= '0;
    end else begin
      if (load) begin
        done_words <= '0;
      end else if (step && pkt_last) begin
        // Running address moves by the finished packet
        done_words <= done_words + size_t'(pkt_len);
      end

      // Header accepted, new packet begins
      if (pkt_open) begin
        pkt_cnt <= '0;
      end else if (step) begin
        pkt_cnt <= pkt_cnt + pkt_len_t'(1);
      end
    end
  end

endmodule

`default_nettype wire

// ==== src/dma_req_config.svh ====
/*
 * Build-time configuration of the DMA request path
 *   Word, address, size and tile id widths
 *   Request table depth and NoC packet length
 *   Header encodings for the DMA packet class and request kinds
 */

`ifndef DMA_REQ_CONFIG_SVH
`define DMA_REQ_CONFIG_SVH

// Address and data word width
`define DMA_ADDR_W 32
// Request size field, counted in words
`define DMA_SIZE_W 12
// Request table depth
`define DMA_TABLE_ENTRIES 4

// Tile addressing
`define DMA_TILE_W 5
`define DMA_TILE_ID 3

// Max flits per NoC packet, header and address flit included
`define DMA_PACKET_FLITS 16
`define DMA_MAX_PAYLOAD (`DMA_PACKET_FLITS - 2)
`define DMA_FLIT_W 34

// Header encodings
`define DMA_CLASS 3'd2
`define DMA_KIND_L2R 2'd0
`define DMA_KIND_R2L 2'd1

`endif

// ==== src/dma_req_flit_builder.sv ====
/*
 * Flit builder of the DMA request path
 *   Header contents for L2R and R2L packets
 *   Running L2R address, R2L size and address flits
 *   Data flits with the last type on packet end
 */

`timescale 1ns/1ps
`default_nettype none

`include "dma_req_config.svh"

module dma_req_flit_builder import dma_req_pkg::*; (
  input  wire req_state_t state,
  input  wire dma_desc_t  desc,
  input  wire entry_idx_t grant_idx,
  input  wire size_t      done_words,
  input  wire pkt_len_t   pkt_len,
  input  wire logic       pkt_last,
  input  wire word_t      data_word,
  output noc_flit_t       flit
);

  header_t hdr;

  // Fields common to both header kinds
  always_comb begin
    hdr        = '0;
    hdr.dest   = desc.rtile;
    hdr.pclass = `DMA_CLASS;
    hdr.pkt_id = grant_idx;
    hdr.src    = tile_t'(`DMA_TILE_ID);
    if (state == st_l2r_hdr) begin
      hdr.kind = `DMA_KIND_L2R;
      hdr.last = ((done_words + size_t'(pkt_len)) == desc.size);
      hdr.size = size_t'(pkt_len);
    end else begin
      // R2L is one packet, size field stays zero
      hdr.kind = `DMA_KIND_R2L;
      hdr.last = 1'b1;
    end
  end

  always_comb begin
    flit = '{ftype: flit_payload, content: '0};
    unique case (state)
      st_l2r_hdr, st_r2l_hdr: begin
        flit.ftype   = flit_header;
        flit.content = hdr;
      end
      st_l2r_addr: begin
        // Byte address of the first word in this packet
        flit.content = desc.raddr + (addr_t'(done_words) << 2);
      end
      st_l2r_data: begin
        flit.ftype   = pkt_last ? flit_last : flit_payload;
        flit.content = data_word;
      end
      st_r2l_size:  flit.content = word_t'(desc.size);
      st_r2l_raddr: flit.content = desc.raddr;
      st_r2l_laddr: begin
        flit.ftype   = flit_last;
        flit.content = desc.laddr;
      end
      default: begin
        flit = '{ftype: flit_payload, content: '0};
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== src/dma_req_fsm.sv ====
/*
 * Request sequencer of the DMA request path
 *   L2R: header, address and data flits per packet
 *   R2L: header, size, remote and local address flits
 *   Strobes for the burst counter and the arbiter
 */

`timescale 1ns/1ps
`default_nettype none

module dma_req_fsm import dma_req_pkg::*; (
  input  wire logic clk,
  input  wire logic rst,
  input  wire logic start,
  input  wire logic is_l2r,
  input  wire logic flit_ready,
  input  wire logic data_valid,
  input  wire logic pkt_last,
  input  wire logic req_last,
  output req_state_t state,
  output logic      idle,
  output logic      flit_valid,
  output logic      data_ready,
  output logic      load,
  output logic      pkt_open,
  output logic      step,
  output logic      issue_done
);

  req_state_t nxt_state;
  logic       data_xfer;

  assign idle = (state == st_idle);

  // Data word leaves only when source and NoC agree
  assign data_xfer = (state == st_l2r_data) && data_valid && flit_ready;

  ////////////////////////////////////////////////////////////////////
  // Next state and strobes
  ////////////////////////////////////////////////////////////////////

  always_comb begin
    nxt_state  = state;
    flit_valid = 1'b0;
    data_ready = 1'b0;
    load       = 1'b0;
    pkt_open   = 1'b0;
    step       = 1'b0;
    issue_done = 1'b0;

    unique case (state)
      st_idle: begin
        // Restart request word count
        load = start;
        if (start) begin
          nxt_state = is_l2r ? st_l2r_hdr : st_r2l_hdr;
        end
      end

      // L2R packet
      st_l2r_hdr: begin
        flit_valid = 1'b1;
        if (flit_ready) begin
          pkt_open  = 1'b1;
          nxt_state = st_l2r_addr;
        end
      end
      st_l2r_addr: begin
        flit_valid = 1'b1;
        if (flit_ready) begin
          nxt_state = st_l2r_data;
        end
      end
      st_l2r_data: begin
        // Valid comes straight from the source
        flit_valid = data_valid;
        data_ready = data_xfer;
        step       = data_xfer;
        if (data_xfer && pkt_last) begin
          issue_done = req_last;
          nxt_state  = req_last ? st_idle : st_l2r_hdr;
        end
      end

      // R2L request, always one packet
      st_r2l_hdr: begin
        flit_valid = 1'b1;
        if (flit_ready) begin
          nxt_state = st_r2l_size;
        end
      end
      st_r2l_size: begin
        flit_valid = 1'b1;
        if (flit_ready) begin
          nxt_state = st_r2l_raddr;
        end
      end
      st_r2l_raddr: begin
        flit_valid = 1'b1;
        if (flit_ready) begin
          nxt_state = st_r2l_laddr;
        end
      end
      st_r2l_laddr: begin
        flit_valid = 1'b1;
        if (flit_ready) begin
          issue_done = 1'b1;
          nxt_state  = st_idle;
        end
      end

      default: begin
        nxt_state = st_idle;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= st_idle;
    end else begin
      state <= nxt_state;
    end
  end

endmodule

`default_nettype wire

// ==== src/dma_req_pkg.sv ====
/*
 * Shared types of the DMA request path
 *   Width typedefs for addresses, words, sizes, tiles and table indices
 *   Flit type and request FSM state enums
 *   Descriptor, flit and header structs
 */

`default_nettype none

`include "dma_req_config.svh"

package dma_req_pkg;

  ////////////////////////////////////////////////////////////////////
  // Plain vectors
  ////////////////////////////////////////////////////////////////////

  typedef logic [`DMA_ADDR_W-1:0]                addr_t;
  typedef logic [`DMA_ADDR_W-1:0]                word_t;
  typedef logic [`DMA_SIZE_W-1:0]                size_t;
  typedef logic [`DMA_TILE_W-1:0]                tile_t;
  typedef logic [`DMA_TABLE_ENTRIES-1:0]         entry_mask_t;
  typedef logic [$clog2(`DMA_TABLE_ENTRIES)-1:0] entry_idx_t;
  // Holds 0..DMA_PACKET_FLITS
  typedef logic [$clog2(`DMA_PACKET_FLITS):0]    pkt_len_t;

  ////////////////////////////////////////////////////////////////////
  // Enums
  ////////////////////////////////////////////////////////////////////

  typedef enum logic [1:0] {
    flit_payload = 2'b00,
    flit_header  = 2'b01,
    flit_last    = 2'b10
  } flit_type_t;

  typedef enum logic [2:0] {
    st_idle,
    st_l2r_hdr,
    st_l2r_addr,
    st_l2r_data,
    st_r2l_hdr,
    st_r2l_size,
    st_r2l_raddr,
    st_r2l_laddr
  } req_state_t;

  ////////////////////////////////////////////////////////////////////
  // Structs
  ////////////////////////////////////////////////////////////////////

  // One request table entry, dir 1 means L2R
  typedef struct packed {
    logic  dir;
    tile_t rtile;
    addr_t laddr;
    addr_t raddr;
    size_t size;
  } dma_desc_t;

  typedef struct packed {
    flit_type_t ftype;
    word_t      content;
  } noc_flit_t;

  // Content of a header flit, MSB first
  typedef struct packed {
    tile_t      dest;
    logic [2:0] pclass;
    entry_idx_t pkt_id;
    tile_t      src;
    logic [1:0] kind;
    logic       last;
    logic [1:0] rsvd;
    size_t      size;
  } header_t;

endpackage

`default_nettype wire
